// ==== rtl/nocPkg.sv ====
package nocPkg;

  localparam int numPorts = 5;
  localparam int bufDepth = 4;  // Input FIFO depth and initial credits.

  typedef logic [2:0] flitIdT;
  typedef logic [1:0] coordT;
  typedef logic [11:0] pktLenT;  // Flits per packet, head included.
  typedef logic [2:0] creditT;
  typedef logic [2:0] portSelT;

  localparam portSelT portL = 3'd0;
  localparam portSelT portN = 3'd1;
  localparam portSelT portE = 3'd2;
  localparam portSelT portW = 3'd3;
  localparam portSelT portS = 3'd4;

  localparam flitIdT flitHead = 3'b001;
  localparam flitIdT flitBody = 3'b010;
  localparam flitIdT flitTail = 3'b100;

  typedef struct packed {
    flitIdT flitId;
    coordT destX;
    coordT destY;
    logic [15:0] payload;  // Head carries pktLenT in low bits.
  } flitT;

  typedef struct packed {
    logic valid;
    flitT flit;
  } linkT;

  typedef enum logic [2:0] {
    arbIdle,
    grantL,
    grantN,
    grantE,
    grantW,
    grantS
  } arbStateT;

endpackage

// ==== rtl/inputPort.sv ====
`timescale 1ns/100ps

module inputPort #(
  parameter nocPkg::coordT routerX = 2'd1,
  parameter nocPkg::coordT routerY = 2'd1
) (
  input  logic clk,
  input  logic rst,
  input  nocPkg::linkT inLink,
  input  logic deq,
  output logic [nocPkg::numPorts-1:0] req,
  output nocPkg::flitT headFlit,
  output logic creditOut
);

  nocPkg::flitT mem [nocPkg::bufDepth];
  logic [$clog2(nocPkg::bufDepth)-1:0] wrPtr, rdPtr;
  nocPkg::creditT fillCount;
  nocPkg::portSelT routeReg, routeFront;
  nocPkg::flitT front;
  logic full, empty;

  assign full = fillCount == nocPkg::creditT'(nocPkg::bufDepth);
  assign empty = fillCount == '0;
  assign front = mem[rdPtr];
  assign headFlit = empty ? '0 : front;  // Stale entries must not look like heads.

  // XY routing, X first. Y grows toward North.
  always_comb
  begin
    routeFront = routeReg;
    if (front.flitId == nocPkg::flitHead)
    begin
      if (front.destX > routerX)
        routeFront = nocPkg::portE;
      else if (front.destX < routerX)
        routeFront = nocPkg::portW;
      else if (front.destY > routerY)
        routeFront = nocPkg::portN;
      else if (front.destY < routerY)
        routeFront = nocPkg::portS;
      else
        routeFront = nocPkg::portL;
    end
  end

  assign req = empty ? '0 : ({{(nocPkg::numPorts-1){1'b0}}, 1'b1} << routeFront);

  always_ff @(posedge clk)
  begin
    if (inLink.valid)
      mem[wrPtr] <= inLink.flit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fillCount <= '0;
      routeReg <= nocPkg::portL;
      creditOut <= 1'b0;
    end
    else
    begin
      if (inLink.valid)
        wrPtr <= wrPtr + 1'b1;
      if (deq)
        rdPtr <= rdPtr + 1'b1;
      if (deq && front.flitId == nocPkg::flitHead)
        routeReg <= routeFront;  // Body and tail follow the head.
      fillCount <= fillCount + nocPkg::creditT'(inLink.valid) - nocPkg::creditT'(deq);
      creditOut <= deq;
    end
  end

  // Upstream credit accounting keeps the FIFO from overflowing.
  assert property (@(posedge clk) disable iff (rst) inLink.valid |-> !full)
    else $error("inputPort push while FIFO full");
  assert property (@(posedge clk) disable iff (rst) deq |-> !empty)
    else $error("inputPort dequeue while FIFO empty");

endmodule

// ==== rtl/packetTimer.sv ====
`timescale 1ns/100ps

module packetTimer (
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT headFlit,
  input  logic runTimer,
  output logic timesUp
);

  nocPkg::pktLenT pktLen;
  nocPkg::pktLenT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen <= '0;
      count <= '0;
    end
    else
    begin
      if (headFlit.flitId == nocPkg::flitHead)
        pktLen <= headFlit.payload[$bits(nocPkg::pktLenT)-1:0];
      if (timesUp)
        count <= '0;  // Grant drops with it.
      else if (runTimer)
        count <= count + 1'b1;  // One per transferred flit.
    end
  end

  assign timesUp = count == pktLen;

endmodule

// ==== rtl/switchArbiter.sv ====
`timescale 1ns/100ps

module switchArbiter (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::numPorts-1:0] req,
  input  nocPkg::flitT headFlit [nocPkg::numPorts],
  input  logic xfer,
  output logic [nocPkg::numPorts-1:0] grant
);

  nocPkg::arbStateT state, nextState;
  nocPkg::portSelT holder;
  logic held;
  logic [nocPkg::numPorts-1:0] runTimer;
  logic [nocPkg::numPorts-1:0] timesUp;

  function automatic nocPkg::arbStateT grantState(input nocPkg::portSelT p);
    case (p)
      nocPkg::portL: return nocPkg::grantL;
      nocPkg::portN: return nocPkg::grantN;
      nocPkg::portE: return nocPkg::grantE;
      nocPkg::portW: return nocPkg::grantW;
      nocPkg::portS: return nocPkg::grantS;
      default: return nocPkg::arbIdle;
    endcase
  endfunction

  always_comb
  begin
    held = 1'b1;
    holder = nocPkg::portL;
    case (state)
      nocPkg::grantL: holder = nocPkg::portL;
      nocPkg::grantN: holder = nocPkg::portN;
      nocPkg::grantE: holder = nocPkg::portE;
      nocPkg::grantW: holder = nocPkg::portW;
      nocPkg::grantS: holder = nocPkg::portS;
      default: held = 1'b0;
    endcase
  end

  // Masked on timesUp so the holder's next packet cannot slip through.
  assign grant = (held && !timesUp[holder])
    ? ({{(nocPkg::numPorts-1){1'b0}}, 1'b1} << holder) : '0;

  assign runTimer = grant & {nocPkg::numPorts{xfer}};

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : genTimer
    packetTimer timer (
      .clk(clk),
      .rst(rst),
      .headFlit(headFlit[i]),
      .runTimer(runTimer[i]),
      .timesUp(timesUp[i])
    );
  end

  // Search starts after the holder; from idle, L comes first.
  always_comb
  begin
    nocPkg::portSelT base;
    nocPkg::portSelT cand;
    logic found;
    base = held ? holder : nocPkg::portS;
    found = 1'b0;
    cand = base;
    nextState = state;
    if (!held || timesUp[holder])
    begin
      nextState = nocPkg::arbIdle;
      for (int k = 1; k <= nocPkg::numPorts; k++)
      begin
        cand = nocPkg::portSelT'((int'(base) + k) % nocPkg::numPorts);
        if (!found && req[cand])
        begin
          nextState = grantState(cand);
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::arbIdle;
    else
      state <= nextState;
  end

  // A fresh grant lands on an input that still requests this output.
  assert property (@(posedge clk) disable iff (rst)
    ($past(grant) == '0 && grant != '0) |-> (grant & req) != '0)
    else $error("switchArbiter granted an input without a request");
  // Head length must end the grant right after the tail leaves.
  assert property (@(posedge clk) disable iff (rst)
    (xfer && headFlit[holder].flitId == nocPkg::flitTail) |=> grant == '0)
    else $error("switchArbiter grant outlived the tail flit");

endmodule

// ==== rtl/crossbar.sv ====
`timescale 1ns/100ps

module crossbar (
  input  logic [nocPkg::numPorts-1:0] grant [nocPkg::numPorts],
  input  nocPkg::flitT headFlit [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] req [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] hasCredit,
  output nocPkg::flitT outFlit [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] xfer,
  output logic [nocPkg::numPorts-1:0] deq
);

  // Grant is indexed by output, req by input.
  always_comb
  begin
    for (int o = 0; o < nocPkg::numPorts; o++)
    begin
      outFlit[o] = '0;
      xfer[o] = 1'b0;
      for (int i = 0; i < nocPkg::numPorts; i++)
      begin
        if (grant[o][i])
        begin
          outFlit[o] = headFlit[i];
          xfer[o] = req[i][o] && hasCredit[o];
        end
      end
    end
  end

  // Each transfer pops its source input.
  always_comb
  begin
    deq = '0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      for (int o = 0; o < nocPkg::numPorts; o++)
      begin
        if (xfer[o] && grant[o][i])
          deq[i] = 1'b1;
      end
    end
  end

endmodule

// ==== rtl/outputPort.sv ====
`timescale 1ns/100ps

module outputPort (
  input  logic clk,
  input  logic rst,
  input  nocPkg::flitT outFlit,
  input  logic xfer,
  input  logic creditIn,
  output logic hasCredit,
  output nocPkg::linkT outLink
);

  nocPkg::creditT credits;
  logic validReg;
  nocPkg::flitT flitReg;

  assign hasCredit = credits != '0;
  assign outLink = '{valid: validReg, flit: flitReg};

  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= nocPkg::creditT'(nocPkg::bufDepth);  // Downstream FIFO empty.
    else
    begin
      case ({xfer, creditIn})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      validReg <= 1'b0;
    else
      validReg <= xfer;
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
      flitReg <= outFlit;
  end

  assert property (@(posedge clk) disable iff (rst) xfer |-> credits != '0)
    else $error("outputPort send without credit");
  assert property (@(posedge clk) disable iff (rst)
    (creditIn && !xfer) |-> credits != nocPkg::creditT'(nocPkg::bufDepth))
    else $error("outputPort credit count above bufDepth");

endmodule

// ==== rtl/nocRouter.sv ====
`timescale 1ns/100ps

module nocRouter #(
  parameter nocPkg::coordT routerX = 2'd1,
  parameter nocPkg::coordT routerY = 2'd1
) (
  input  logic clk,
  input  logic rst,
  input  nocPkg::linkT inLink [nocPkg::numPorts],
  output logic [nocPkg::numPorts-1:0] creditOut,
  output nocPkg::linkT outLink [nocPkg::numPorts],
  input  logic [nocPkg::numPorts-1:0] creditIn
);

  logic [nocPkg::numPorts-1:0] req [nocPkg::numPorts];  // By input.
  logic [nocPkg::numPorts-1:0] reqToOut [nocPkg::numPorts];  // By output.
  logic [nocPkg::numPorts-1:0] grant [nocPkg::numPorts];
  nocPkg::flitT headFlit [nocPkg::numPorts];
  nocPkg::flitT outFlit [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] deq, xfer, hasCredit;

  for (genvar p = 0; p < nocPkg::numPorts; p++)
  begin : genPort
    for (genvar i = 0; i < nocPkg::numPorts; i++)
    begin : genReq
      assign reqToOut[p][i] = req[i][p];
    end

    inputPort #(.routerX(routerX), .routerY(routerY)) inPort (
      .clk(clk),
      .rst(rst),
      .inLink(inLink[p]),
      .deq(deq[p]),
      .req(req[p]),
      .headFlit(headFlit[p]),
      .creditOut(creditOut[p])
    );

    switchArbiter arbiter (
      .clk(clk),
      .rst(rst),
      .req(reqToOut[p]),
      .headFlit(headFlit),
      .xfer(xfer[p]),
      .grant(grant[p])
    );

    outputPort outPort (
      .clk(clk),
      .rst(rst),
      .outFlit(outFlit[p]),
      .xfer(xfer[p]),
      .creditIn(creditIn[p]),
      .hasCredit(hasCredit[p]),
      .outLink(outLink[p])
    );
  end

  crossbar xbar (
    .grant(grant),
    .headFlit(headFlit),
    .req(req),
    .hasCredit(hasCredit),
    .outFlit(outFlit),
    .xfer(xfer),
    .deq(deq)
  );

endmodule

// ==== verification/routerTb.sv ====
`timescale 1ns/100ps

module routerTb;

  logic clk;
  logic rst;
  nocPkg::linkT inLink [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] creditOut;
  nocPkg::linkT outLink [nocPkg::numPorts];
  logic [nocPkg::numPorts-1:0] creditIn;
  logic [nocPkg::numPorts-1:0] stall;  // Downstream holds its credits.
  nocPkg::flitT sendQ [nocPkg::numPorts][$];
  nocPkg::flitT expQ [nocPkg::numPorts][$];  // Expected order per output.
  nocPkg::flitT rxQ [nocPkg::numPorts][$];
  int rxCycle [nocPkg::numPorts][$];
  int sentCount [nocPkg::numPorts] = '{default: 0};
  int creditCount [nocPkg::numPorts] = '{default: 0};  // Sender credit is bufDepth minus the gap.
  int owed [nocPkg::numPorts] = '{default: 0};
  int headCycle [nocPkg::numPorts] = '{default: 0};
  int cycle = 0;
  int seed = 98104;
  int checkCount = 0;
  int errorCount = 0;
  int timeoutCount = 0;

  nocRouter #(.routerX(2'd1), .routerY(2'd1)) dut (
    .clk(clk), .rst(rst), .inLink(inLink), .creditOut(creditOut),
    .outLink(outLink), .creditIn(creditIn)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle = cycle + 1;
    #1;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      inLink[p] = '0;
      creditIn[p] = !stall[p] && owed[p] > 0;  // One credit per received flit.
      owed[p] = owed[p] - int'(creditIn[p]);
      if (sendQ[p].size() > 0 && sentCount[p] - creditCount[p] < nocPkg::bufDepth)
      begin
        inLink[p].valid = 1'b1;
        inLink[p].flit = sendQ[p].pop_front();
        if (inLink[p].flit.flitId == nocPkg::flitHead)
          headCycle[p] = cycle;
        sentCount[p] = sentCount[p] + 1;
      end
    end
  end

  // Outputs are sampled mid cycle.
  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < nocPkg::numPorts; p++)
      begin
        creditCount[p] = creditCount[p] + int'(creditOut[p]);
        if (outLink[p].valid)
        begin
          rxQ[p].push_back(outLink[p].flit);
          rxCycle[p].push_back(cycle);
          owed[p] = owed[p] + 1;
        end
      end
    end
  end

  task automatic checkValue(input string name, input int got, input int expected);
    checkCount = checkCount + 1;
    assert (got == expected)
    else
    begin
      errorCount = errorCount + 1;
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic reportTimeout(input string what);
    timeoutCount = timeoutCount + 1;
    errorCount = errorCount + 1;
    $display("TIMEOUT at %0t: %s", $time, what);
  endtask

  // The head payload carries the packet length in its low bits.
  task automatic queuePacket(input int src, input int dst, input int destX, input int destY,
                             input int len);
    nocPkg::flitT f;
    for (int k = 0; k < len; k++)
    begin
      f.flitId = (k == 0) ? nocPkg::flitHead
        : (k == len - 1) ? nocPkg::flitTail : nocPkg::flitBody;
      f.destX = nocPkg::coordT'(destX);
      f.destY = nocPkg::coordT'(destY);
      f.payload = 16'($random(seed));
      if (k == 0)
        f.payload[11:0] = nocPkg::pktLenT'(len);
      sendQ[src].push_back(f);
      expQ[dst].push_back(f);
    end
  endtask

  task automatic drainAndCheck(input string test);
    int waited;
    logic done;
    waited = 0;
    done = 1'b0;
    while (!done && waited < 100)
    begin
      @(posedge clk);
      waited = waited + 1;
      done = 1'b1;
      for (int p = 0; p < nocPkg::numPorts; p++)
        if (rxQ[p].size() < expQ[p].size() || creditCount[p] != sentCount[p])
          done = 1'b0;
    end
    if (!done)
      reportTimeout({test, " test did not drain within 100 cycles"});
    repeat (4) @(posedge clk);  // Stray flits would land here.
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      checkValue($sformatf("%s outLink[%0d] flit count", test, p), rxQ[p].size(),
                 expQ[p].size());
      for (int k = 0; k < rxQ[p].size() && k < expQ[p].size(); k++)
        checkValue($sformatf("%s outLink[%0d] flit %0d", test, p, k), int'(rxQ[p][k]),
                   int'(expQ[p][k]));
      rxQ[p].delete();
      expQ[p].delete();
    end
  endtask

  task automatic latencyTest();
    queuePacket(nocPkg::portL, nocPkg::portE, 2, 1, 3);
    drainAndCheck("latency");
    for (int k = 0; k < rxCycle[nocPkg::portE].size(); k++)
      checkValue($sformatf("East flit %0d latency", k),
                 rxCycle[nocPkg::portE][k] - headCycle[nocPkg::portL], 3 + k);
  endtask

  // Router sits at (1,1). X resolves first.
  task automatic routingTest();
    queuePacket(nocPkg::portN, nocPkg::portE, 2, 0, 2);
    queuePacket(nocPkg::portE, nocPkg::portW, 0, 2, 2);
    queuePacket(nocPkg::portW, nocPkg::portL, 1, 1, 2);
    queuePacket(nocPkg::portL, nocPkg::portS, 1, 0, 2);
    queuePacket(nocPkg::portS, nocPkg::portN, 1, 2, 3);
    drainAndCheck("routing");
  endtask

  task automatic contentionTest();
    queuePacket(nocPkg::portN, nocPkg::portE, 2, 1, 4);  // From idle North wins.
    queuePacket(nocPkg::portS, nocPkg::portE, 2, 1, 4);
    drainAndCheck("contention");
  endtask

  task automatic rotationTest();
    for (int r = 0; r < 2; r++)
    begin
      queuePacket(nocPkg::portL, nocPkg::portE, 2, 1, 2);
      queuePacket(nocPkg::portN, nocPkg::portE, 2, 1, 2);
      queuePacket(nocPkg::portW, nocPkg::portE, 2, 1, 2);
    end
    drainAndCheck("rotation");
  endtask

  task automatic backPressureTest();
    int waited;
    waited = 0;
    stall[nocPkg::portE] = 1'b1;
    queuePacket(nocPkg::portL, nocPkg::portE, 2, 1, 6);
    while (rxQ[nocPkg::portE].size() < nocPkg::bufDepth && waited < 50)
    begin
      @(posedge clk);
      waited = waited + 1;
    end
    if (rxQ[nocPkg::portE].size() < nocPkg::bufDepth)
      reportTimeout("East output did not use up its credits within 50 cycles");
    repeat (10) @(posedge clk);  // Output must stay stopped.
    checkValue("East flit count with credits stalled", rxQ[nocPkg::portE].size(),
               nocPkg::bufDepth);
    stall[nocPkg::portE] = 1'b0;
    drainAndCheck("back-pressure");
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    stall = '0;
    creditIn = '0;
    for (int p = 0; p < nocPkg::numPorts; p++)
      inLink[p] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int p = 0; p < nocPkg::numPorts; p++)
    begin
      checkValue($sformatf("outLink[%0d].valid after reset", p), outLink[p].valid, 0);
      checkValue($sformatf("creditOut[%0d] after reset", p), creditOut[p], 0);
    end
    latencyTest();
    routingTest();
    contentionTest();
    rotationTest();
    backPressureTest();
    for (int p = 0; p < nocPkg::numPorts; p++)
      checkValue($sformatf("creditOut[%0d] pulse count", p), creditCount[p], sentCount[p]);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/nocPkg.sv
rtl/inputPort.sv
rtl/packetTimer.sv
rtl/switchArbiter.sv
rtl/crossbar.sv
rtl/outputPort.sv
rtl/nocRouter.sv
verification/routerTb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Build and run the router testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module routerTb -f build.f \
  -Mdir obj_dir -o routerSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi
./obj_dir/routerSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -qxF '** PASS **' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
